// File: verilog/dsp_pkg.sv
package dsp_pkg;

	localparam int data_width = 16;
	localparam int full_width = 40;
	localparam int n_blocks = 32;
	localparam int block_addr_w = $clog2(n_blocks);
	localparam int n_channels = 16;
	localparam int ch_addr_w = $clog2(n_channels);
	localparam int out_channel = 0;
	localparam int in_channel = 1;

	typedef logic signed [data_width-1:0] sample_t;
	typedef logic signed [full_width-1:0] acc_t;

	localparam sample_t sample_max = {1'b0, {(data_width - 1){1'b1}}};
	localparam sample_t sample_min = {1'b1, {(data_width - 1){1'b0}}};

	typedef enum logic [3:0] {
		OP_NOP    = 4'd0,
		OP_MADD   = 4'd1,
		OP_MAC    = 4'd2,
		OP_MOVACC = 4'd3
	} opcode_t;

	// Top bit set picks a block register (bit 0 says which), else a channel
	typedef logic [4:0] src_t;

	// MADD and MOVACC layout
	typedef struct packed {
		opcode_t opcode;
		logic [ch_addr_w-1:0] dest;
		src_t src_a;
		src_t src_b;
		src_t src_c;
		logic [4:0] shift;
		logic sat_disable;
		logic [2:0] spare;
	} madd_fmt_t;

	// MAC layout
	typedef struct packed {
		opcode_t opcode;
		logic [ch_addr_w-1:0] dest;
		src_t src_a;
		src_t src_b;
		logic clear;
		logic [12:0] spare;
	} mac_fmt_t;

	// Opcode sits in the same top nibble of both views
	typedef union packed {
		madd_fmt_t madd;
		mac_fmt_t mac;
	} instr_t;

	function automatic sample_t saturate(acc_t value);
		if (value > acc_t'(sample_max))
			return sample_max;
		if (value < acc_t'(sample_min))
			return sample_min;
		return value[data_width-1:0];
	endfunction

endpackage

// File: verilog/dsp_if.sv
`timescale 1ns/1ps

// Sequencer to operand fetch
interface issue_if;
	logic valid;
	dsp_pkg::instr_t instr;
	dsp_pkg::sample_t reg0;
	dsp_pkg::sample_t reg1;

	modport source (output valid, instr, reg0, reg1);
	modport sink (input valid, instr, reg0, reg1);
endinterface

// Operand fetch to the execution units
interface exec_if;
	logic valid;
	dsp_pkg::opcode_t op;
	dsp_pkg::sample_t arg_a;
	dsp_pkg::sample_t arg_b;
	dsp_pkg::sample_t arg_c;
	logic [4:0] shift;
	logic sat_disable;
	logic clear;
	logic [dsp_pkg::ch_addr_w-1:0] dest;

	modport source (output valid, op, arg_a, arg_b, arg_c, shift, sat_disable, clear, dest);
	modport sink (input valid, op, arg_a, arg_b, arg_c, shift, sat_disable, clear, dest);
endinterface

// One execution unit to the channel file
interface result_if;
	logic valid;
	logic [dsp_pkg::ch_addr_w-1:0] dest;
	dsp_pkg::sample_t value;

	modport source (output valid, dest, value);
	modport sink (input valid, dest, value);
endinterface

// File: verilog/block_sequencer.sv
`timescale 1ns/1ps

module block_sequencer (
	input logic clk,
	input logic reset,
	input logic tick,
	input logic cmd_instr_write,
	input logic cmd_reg_write,
	input logic cmd_reg_sel,
	input logic [dsp_pkg::block_addr_w-1:0] cmd_block,
	input dsp_pkg::instr_t cmd_instr,
	input dsp_pkg::sample_t cmd_reg_val,
	input logic done,
	output logic busy,
	issue_if.source issue
);

	dsp_pkg::instr_t instr_mem [dsp_pkg::n_blocks];
	dsp_pkg::sample_t reg0_mem [dsp_pkg::n_blocks];
	dsp_pkg::sample_t reg1_mem [dsp_pkg::n_blocks];

	// Count can reach n_blocks, so one bit wider than a block index
	logic [dsp_pkg::block_addr_w:0] n_loaded;
	logic [dsp_pkg::block_addr_w-1:0] cur_block;
	logic [dsp_pkg::block_addr_w-1:0] next_block;
	logic start;
	logic last;
	logic advance;

	assign start = tick && !busy;
	assign last = ({1'b0, cur_block} + 1'b1) == n_loaded;
	assign advance = busy && done && !last;
	assign next_block = start ? '0 : cur_block + 1'b1;

	// Host program and register loads
	always_ff @(posedge clk) begin
		if (cmd_instr_write)
			instr_mem[cmd_block] <= cmd_instr;
		if (cmd_reg_write && !cmd_reg_sel)
			reg0_mem[cmd_block] <= cmd_reg_val;
		if (cmd_reg_write && cmd_reg_sel)
			reg1_mem[cmd_block] <= cmd_reg_val;
	end

	always_ff @(posedge clk) begin
		if (start || advance) begin
			issue.instr <= instr_mem[next_block];
			issue.reg0 <= reg0_mem[next_block];
			issue.reg1 <= reg1_mem[next_block];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			issue.valid <= 1'b0;
			cur_block <= '0;
			n_loaded <= '0;
		end else begin
			issue.valid <= 1'b0;
			if (cmd_instr_write && {1'b0, cmd_block} >= n_loaded)
				n_loaded <= {1'b0, cmd_block} + 1'b1;

			if (start) begin
				busy <= 1'b1;
				cur_block <= next_block;
				issue.valid <= n_loaded != '0;
			end else if (busy) begin
				// Empty program ends at once, otherwise wait for the last commit
				if (n_loaded == '0 || (done && last)) begin
					busy <= 1'b0;
				end else if (advance) begin
					cur_block <= next_block;
					issue.valid <= 1'b1;
				end
			end
		end
	end

endmodule

// File: verilog/operand_fetch.sv
`timescale 1ns/1ps

module operand_fetch (
	input logic clk,
	input logic reset,
	issue_if.sink issue,
	input dsp_pkg::sample_t channels [dsp_pkg::n_channels],
	input logic committed,
	exec_if.source exec,
	output logic done
);

	dsp_pkg::opcode_t op;
	dsp_pkg::src_t src_a;
	dsp_pkg::src_t src_b;
	dsp_pkg::src_t src_c;
	logic [dsp_pkg::ch_addr_w-1:0] dest;
	logic [4:0] shift;
	logic sat_disable;
	logic clear;
	logic [1:0] local_done;

	function automatic dsp_pkg::sample_t pick(dsp_pkg::src_t src, dsp_pkg::sample_t ch,
			dsp_pkg::sample_t r0, dsp_pkg::sample_t r1);
		if (src[4])
			return src[0] ? r1 : r0;
		return ch;
	endfunction

	// View chosen by opcode
	always_comb begin
		op = issue.instr.madd.opcode;
		if (op == dsp_pkg::OP_MAC) begin
			src_a = issue.instr.mac.src_a;
			src_b = issue.instr.mac.src_b;
			src_c = '0;
			dest = issue.instr.mac.dest;
			shift = '0;
			sat_disable = 1'b0;
			clear = issue.instr.mac.clear;
		end else begin
			src_a = issue.instr.madd.src_a;
			src_b = issue.instr.madd.src_b;
			src_c = issue.instr.madd.src_c;
			dest = issue.instr.madd.dest;
			shift = issue.instr.madd.shift;
			sat_disable = issue.instr.madd.sat_disable;
			clear = 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (issue.valid) begin
			exec.op <= op;
			exec.arg_a <= pick(src_a, channels[src_a[dsp_pkg::ch_addr_w-1:0]], issue.reg0, issue.reg1);
			exec.arg_b <= pick(src_b, channels[src_b[dsp_pkg::ch_addr_w-1:0]], issue.reg0, issue.reg1);
			exec.arg_c <= pick(src_c, channels[src_c[dsp_pkg::ch_addr_w-1:0]], issue.reg0, issue.reg1);
			exec.dest <= dest;
			exec.shift <= shift;
			exec.sat_disable <= sat_disable;
			exec.clear <= clear;
		end
	end

	// Ops without a channel write commit here, delayed to match the write path
	always_ff @(posedge clk) begin
		if (reset) begin
			exec.valid <= 1'b0;
			local_done <= '0;
		end else begin
			exec.valid <= issue.valid;
			local_done[0] <= exec.valid && exec.op != dsp_pkg::OP_MADD
				&& exec.op != dsp_pkg::OP_MOVACC;
			local_done[1] <= local_done[0];
		end
	end

	assign done = committed || local_done[1];

endmodule

// File: verilog/madd_unit.sv
`timescale 1ns/1ps

module madd_unit (
	input logic clk,
	input logic reset,
	exec_if.sink exec,
	result_if.source result
);

	logic signed [2*dsp_pkg::data_width-1:0] product;
	logic signed [2*dsp_pkg::data_width-1:0] scaled;
	dsp_pkg::acc_t sum;
	dsp_pkg::sample_t value;

	always_comb begin
		product = exec.arg_a * exec.arg_b;
		scaled = product >>> exec.shift;
		// c joins sign-extended, wide enough that the sum never wraps
		sum = dsp_pkg::acc_t'(scaled) + dsp_pkg::acc_t'(exec.arg_c);
		if (exec.sat_disable)
			value = sum[dsp_pkg::data_width-1:0];
		else
			value = dsp_pkg::saturate(sum);
	end

	always_ff @(posedge clk) begin
		if (reset)
			result.valid <= 1'b0;
		else
			result.valid <= exec.valid && exec.op == dsp_pkg::OP_MADD;
	end

	always_ff @(posedge clk) begin
		if (exec.valid) begin
			result.dest <= exec.dest;
			result.value <= value;
		end
	end

endmodule

// File: verilog/mac_unit.sv
`timescale 1ns/1ps

module mac_unit (
	input logic clk,
	input logic reset,
	exec_if.sink exec,
	result_if.source result
);

	dsp_pkg::acc_t acc;
	dsp_pkg::acc_t product;
	dsp_pkg::acc_t shifted;

	assign product = dsp_pkg::acc_t'(exec.arg_a * exec.arg_b);
	assign shifted = acc >>> exec.shift;

	always_ff @(posedge clk) begin
		if (reset) begin
			acc <= '0;
			result.valid <= 1'b0;
		end else begin
			// Only MOVACC writes a channel
			result.valid <= exec.valid && exec.op == dsp_pkg::OP_MOVACC;
			if (exec.valid && exec.op == dsp_pkg::OP_MAC)
				acc <= exec.clear ? product : acc + product;
		end
	end

	always_ff @(posedge clk) begin
		if (exec.valid) begin
			result.dest <= exec.dest;
			result.value <= dsp_pkg::saturate(shifted);
		end
	end

endmodule

// File: verilog/channel_file.sv
`timescale 1ns/1ps

module channel_file (
	input logic clk,
	input logic reset,
	input logic tick,
	input dsp_pkg::sample_t sample_in,
	output dsp_pkg::sample_t sample_out,
	result_if.sink madd_res,
	result_if.sink mac_res,
	output dsp_pkg::sample_t channels [dsp_pkg::n_channels],
	output logic committed
);

	logic wr_en;
	logic [dsp_pkg::ch_addr_w-1:0] wr_dest;
	dsp_pkg::sample_t wr_value;

	// At most one unit reports per cycle
	always_comb begin
		wr_en = madd_res.valid || mac_res.valid;
		wr_dest = madd_res.valid ? madd_res.dest : mac_res.dest;
		wr_value = madd_res.valid ? madd_res.value : mac_res.value;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			channels <= '{default: '0};
			sample_out <= '0;
			committed <= 1'b0;
		end else begin
			committed <= wr_en;
			if (wr_en)
				channels[wr_dest] <= wr_value;
			// Sample capture comes last so it wins over a result write
			if (tick) begin
				sample_out <= channels[dsp_pkg::out_channel];
				channels[dsp_pkg::in_channel] <= sample_in;
			end
		end
	end

endmodule

// File: verilog/dsp_core.sv
`timescale 1ns/1ps

module dsp_core (
	input logic clk,
	input logic reset,
	input logic tick,
	input dsp_pkg::sample_t sample_in,
	output dsp_pkg::sample_t sample_out,
	output logic busy,
	input logic cmd_instr_write,
	input logic cmd_reg_write,
	input logic [dsp_pkg::block_addr_w-1:0] cmd_block,
	input logic cmd_reg_sel,
	input dsp_pkg::instr_t cmd_instr,
	input dsp_pkg::sample_t cmd_reg_val
);

	issue_if issue ();
	exec_if exec ();
	result_if madd_res ();
	result_if mac_res ();

	dsp_pkg::sample_t channels [dsp_pkg::n_channels];
	logic done;
	logic committed;

	block_sequencer sequencer (
		.clk(clk),
		.reset(reset),
		.tick(tick),
		.cmd_instr_write(cmd_instr_write),
		.cmd_reg_write(cmd_reg_write),
		.cmd_reg_sel(cmd_reg_sel),
		.cmd_block(cmd_block),
		.cmd_instr(cmd_instr),
		.cmd_reg_val(cmd_reg_val),
		.done(done),
		.busy(busy),
		.issue(issue)
	);

	operand_fetch fetch (
		.clk(clk),
		.reset(reset),
		.issue(issue),
		.channels(channels),
		.committed(committed),
		.exec(exec),
		.done(done)
	);

	madd_unit madd (
		.clk(clk),
		.reset(reset),
		.exec(exec),
		.result(madd_res)
	);

	mac_unit mac (
		.clk(clk),
		.reset(reset),
		.exec(exec),
		.result(mac_res)
	);

	channel_file chan (
		.clk(clk),
		.reset(reset),
		.tick(tick),
		.sample_in(sample_in),
		.sample_out(sample_out),
		.madd_res(madd_res),
		.mac_res(mac_res),
		.channels(channels),
		.committed(committed)
	);

endmodule

// File: tests/dsp_core_asserts.sv
`timescale 1ns/1ps

module dsp_core_asserts (
	input logic clk,
	input logic reset,
	input logic busy,
	input logic issue_valid,
	input logic exec_valid,
	input logic madd_valid,
	input logic mac_valid,
	input logic done
);

	// Both units share one channel write port
	assert property (@(posedge clk) disable iff (reset) !(madd_valid && mac_valid))
		else $error("MADD and MAC results valid in the same cycle");

	assert property (@(posedge clk) disable iff (reset) issue_valid |-> busy)
		else $error("Block issued while the sequencer is idle");

	// Commit comes back two cycles after exec for every op
	assert property (@(posedge clk) disable iff (reset) exec_valid |-> ##[1:2] done)
		else $error("No commit strobe within two cycles of exec valid");

endmodule

bind dsp_core dsp_core_asserts checks (
	.clk(clk),
	.reset(reset),
	.busy(busy),
	.issue_valid(issue.valid),
	.exec_valid(exec.valid),
	.madd_valid(madd_res.valid),
	.mac_valid(mac_res.valid),
	.done(done)
);

// File: tests/dsp_core_tb.sv
`timescale 1ns/1ps

module dsp_core_tb;

	localparam int clk_period = 4;
	localparam int n_rows = 8;
	localparam int n_samples = 3;
	localparam int watchdog_cycles = n_rows * (n_samples + 1) * 200;

	// One decoded instruction of a test program
	typedef struct packed {
		dsp_pkg::opcode_t op;
		logic [3:0] dest;
		dsp_pkg::src_t a;
		dsp_pkg::src_t b;
		dsp_pkg::src_t c;
		logic [4:0] shift;
		logic sat;
		logic clr;
	} ins_t;

	logic clk;
	logic reset;
	logic tick;
	dsp_pkg::sample_t sample_in;
	dsp_pkg::sample_t sample_out;
	logic busy;
	logic cmd_instr_write;
	logic cmd_reg_write;
	logic [dsp_pkg::block_addr_w-1:0] cmd_block;
	logic cmd_reg_sel;
	dsp_pkg::instr_t cmd_instr;
	dsp_pkg::sample_t cmd_reg_val;

	// Test table with registers packed as {block3, block2, block1, block0}
	int row_rule [n_rows];
	int row_len [n_rows];
	ins_t row_prog [n_rows][4];
	logic [63:0] row_r0 [n_rows];
	logic [63:0] row_r1 [n_rows];
	dsp_pkg::sample_t row_samples [n_rows][n_samples];
	int rows_added = 0;

	dsp_pkg::sample_t m_ch [dsp_pkg::n_channels];
	longint m_acc;
	logic [15:0] lfsr = 16'd85;
	int errors = 0;
	int passed = 0;

	dsp_core UUT (
		.clk(clk),
		.reset(reset),
		.tick(tick),
		.sample_in(sample_in),
		.sample_out(sample_out),
		.busy(busy),
		.cmd_instr_write(cmd_instr_write),
		.cmd_reg_write(cmd_reg_write),
		.cmd_block(cmd_block),
		.cmd_reg_sel(cmd_reg_sel),
		.cmd_instr(cmd_instr),
		.cmd_reg_val(cmd_reg_val)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	initial begin
		#(watchdog_cycles * clk_period);
		$display("Timeout: the DUT never finished its frames");
		$display("TEST FAIL");
		$finish;
	end

	// Taps 16, 14, 13, 11
	function automatic logic [15:0] lfsr_step(logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic dsp_pkg::sample_t random_sample();
		dsp_pkg::sample_t v;
		v = '0;
		for (int n = 0; n < 16; n++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[14:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic ins_t madd_ins(logic [3:0] d, dsp_pkg::src_t sa, dsp_pkg::src_t sb,
			dsp_pkg::src_t sc, logic [4:0] sh, logic sat);
		return '{op: dsp_pkg::OP_MADD, dest: d, a: sa, b: sb, c: sc, shift: sh, sat: sat,
			clr: 1'b0};
	endfunction

	function automatic ins_t mac_ins(dsp_pkg::src_t sa, dsp_pkg::src_t sb, logic clr);
		return '{op: dsp_pkg::OP_MAC, a: sa, b: sb, clr: clr, default: '0};
	endfunction

	function automatic ins_t movacc_ins(logic [3:0] d, logic [4:0] sh);
		return '{op: dsp_pkg::OP_MOVACC, dest: d, shift: sh, default: '0};
	endfunction

	function automatic ins_t nop_ins();
		return '{op: dsp_pkg::OP_NOP, default: '0};
	endfunction

	// NOP whose fields name live operands, so a stray write to channel 0 would show
	function automatic ins_t operand_nop_ins();
		return '{op: dsp_pkg::OP_NOP, dest: 4'd0, a: 5'h01, b: 5'h10, c: 5'h01, shift: 5'd0,
			sat: 1'b0, clr: 1'b0};
	endfunction

	function automatic dsp_pkg::instr_t to_instr(ins_t i);
		dsp_pkg::instr_t u;
		u = '0;
		if (i.op == dsp_pkg::OP_MAC)
			u.mac = '{opcode: i.op, dest: i.dest, src_a: i.a, src_b: i.b, clear: i.clr,
				spare: '0};
		else
			u.madd = '{opcode: i.op, dest: i.dest, src_a: i.a, src_b: i.b, src_c: i.c,
				shift: i.shift, sat_disable: i.sat, spare: '0};
		return u;
	endfunction

	function automatic dsp_pkg::sample_t clamp_sample(longint v);
		if (v > 32767)
			return 16'h7fff;
		if (v < -32768)
			return 16'h8000;
		return v[15:0];
	endfunction

	function automatic dsp_pkg::sample_t resolve_source(dsp_pkg::src_t src,
			dsp_pkg::sample_t r0, dsp_pkg::sample_t r1);
		if (src[4])
			return src[0] ? r1 : r0;
		return m_ch[src[3:0]];
	endfunction

	task automatic add_row(input int rule, input int len, input ins_t p0, input ins_t p1,
			input ins_t p2, input ins_t p3, input logic [63:0] r0, input logic [63:0] r1);
		row_rule[rows_added] = rule;
		row_len[rows_added] = len;
		row_prog[rows_added] = '{p0, p1, p2, p3};
		row_r0[rows_added] = r0;
		row_r1[rows_added] = r1;
		for (int n = 0; n < n_samples; n++)
			row_samples[rows_added][n] = random_sample();
		rows_added++;
	endtask

	// Reference frame outputs old channel 0, captures the input and runs each block in order
	task automatic model_tick(input int r, input dsp_pkg::sample_t s,
			output dsp_pkg::sample_t out);
		ins_t i;
		dsp_pkg::sample_t r0;
		dsp_pkg::sample_t r1;
		longint p;
		out = m_ch[0];
		m_ch[1] = s;
		for (int k = 0; k < row_len[r]; k++) begin
			i = row_prog[r][k];
			r0 = row_r0[r][16*k +: 16];
			r1 = row_r1[r][16*k +: 16];
			p = longint'(resolve_source(i.a, r0, r1)) * longint'(resolve_source(i.b, r0, r1));
			case (i.op)
				dsp_pkg::OP_MADD: begin
					p = (p >>> i.shift) + longint'(resolve_source(i.c, r0, r1));
					m_ch[i.dest] = i.sat ? p[15:0] : clamp_sample(p);
				end
				dsp_pkg::OP_MAC: m_acc = i.clr ? p : m_acc + p;
				dsp_pkg::OP_MOVACC: m_ch[i.dest] = clamp_sample(m_acc >>> i.shift);
				default: ;
			endcase
		end
	endtask

	task automatic apply_reset();
		@(posedge clk);
		reset <= 1'b1;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
	endtask

	task automatic load_program(input int r);
		for (int k = 0; k < row_len[r]; k++) begin
			@(posedge clk);
			cmd_block <= 5'(k);
			cmd_instr <= to_instr(row_prog[r][k]);
			cmd_instr_write <= 1'b1;
			cmd_reg_write <= 1'b1;
			cmd_reg_sel <= 1'b0;
			cmd_reg_val <= row_r0[r][16*k +: 16];
			@(posedge clk);
			cmd_instr_write <= 1'b0;
			cmd_reg_sel <= 1'b1;
			cmd_reg_val <= row_r1[r][16*k +: 16];
		end
		@(posedge clk);
		cmd_reg_write <= 1'b0;
	endtask

	// Tick once and count the cycles that busy stays high
	task automatic send_tick(input dsp_pkg::sample_t s, output int cycles);
		@(posedge clk);
		tick <= 1'b1;
		sample_in <= s;
		@(posedge clk);
		tick <= 1'b0;
		cycles = 0;
		@(negedge clk);
		while (busy) begin
			cycles++;
			@(negedge clk);
		end
	endtask

	initial begin
		int errors_before;
		int cycles;
		int exp_cycles;
		dsp_pkg::sample_t s;
		dsp_pkg::sample_t expected;
		reset = 1'b1;
		tick = 1'b0;
		sample_in = '0;
		cmd_instr_write = 1'b0;
		cmd_reg_write = 1'b0;
		cmd_block = '0;
		cmd_reg_sel = 1'b0;
		cmd_instr = '0;
		cmd_reg_val = '0;

		add_row(1, 1, madd_ins(0, 5'h01, 5'h10, 5'h11, 15, 0), nop_ins(), nop_ins(), nop_ins(),
			64'h7fff, 64'h0);
		add_row(2, 1, madd_ins(0, 5'h10, 5'h11, 5'h01, 0, 0), nop_ins(), nop_ins(), nop_ins(),
			64'h4000, 64'h4000);
		add_row(2, 1, madd_ins(0, 5'h10, 5'h11, 5'h01, 0, 0), nop_ins(), nop_ins(), nop_ins(),
			64'h4000, 64'hc000);
		add_row(2, 1, madd_ins(0, 5'h10, 5'h11, 5'h01, 4, 1), nop_ins(), nop_ins(), nop_ins(),
			64'h1234, 64'h0567);
		add_row(3, 4, mac_ins(5'h01, 5'h10, 1), mac_ins(5'h01, 5'h10, 0),
			mac_ins(5'h01, 5'h10, 0), movacc_ins(0, 16), 64'h0000_7fff_5000_6000, 64'h0);
		add_row(4, 2, madd_ins(5, 5'h01, 5'h10, 5'h11, 14, 0),
			madd_ins(0, 5'h05, 5'h10, 5'h11, 13, 0), nop_ins(), nop_ins(),
			64'h0000_0000_2000_4000, 64'h0000_0000_0003_0100);
		add_row(5, 0, nop_ins(), nop_ins(), nop_ins(), nop_ins(), 64'h0, 64'h0);
		add_row(5, 2, operand_nop_ins(), operand_nop_ins(), nop_ins(), nop_ins(),
			64'h0000_0000_4000_4000, 64'h0000_0000_0100_0100);

		for (int r = 0; r < n_rows; r++) begin
			apply_reset();
			m_ch = '{default: '0};
			m_acc = 0;
			load_program(r);
			errors_before = errors;
			exp_cycles = (row_len[r] == 0) ? 1 : 4 * row_len[r];
			// Last tick only flushes the final result out to sample_out
			for (int t = 0; t <= n_samples; t++) begin
				s = (t < n_samples) ? row_samples[r][t] : '0;
				model_tick(r, s, expected);
				send_tick(s, cycles);
				if (sample_out !== expected) begin
					$display("Fail row %0d tick %0d: sample_out expected %h got %h",
						r, t, expected, sample_out);
					errors++;
				end
				if (cycles != exp_cycles) begin
					$display("Fail row %0d tick %0d: busy cycles expected %h got %h",
						r, t, exp_cycles, cycles);
					errors++;
				end
			end
			if (errors == errors_before) begin
				$display("Row %0d (rule %0d) passed", r, row_rule[r]);
				passed++;
			end else begin
				$display("Row %0d (rule %0d) failed", r, row_rule[r]);
			end
		end

		$display("Rows run %0d, passed %0d, failed %0d, errors %0d",
			n_rows, passed, n_rows - passed, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// File: dsp_core.f
verilog/dsp_pkg.sv
verilog/dsp_if.sv
verilog/block_sequencer.sv
verilog/operand_fetch.sv
verilog/madd_unit.sv
verilog/mac_unit.sv
verilog/channel_file.sv
verilog/dsp_core.sv
tests/dsp_core_asserts.sv
tests/dsp_core_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the dsp_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module dsp_core_tb -f dsp_core.f

output=$(./obj_dir/Vdsp_core_tb)
echo "$output"

if grep -q "TEST PASS" <<< "$output"; then
	exit 0
fi
exit 1
